// File: run.sh
#!/bin/sh
# compile and run the tlb testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_tlb -f src.f -o tb_tlb_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/tb_tlb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Regression passed$"; then
    exit 0
fi
exit 1

// File: src.f
sv32_pkg.sv
tlb_pkg.sv
tlb_array.sv
tlb_lookup.sv
tlb_sweep.sv
tlb_control.sv
tlb.sv
tb_tlb.sv

// File: sv32_pkg.sv
package sv32_pkg;

    // sv32 field widths
    localparam int VPN_W    = 20;   // virtual page number
    localparam int OFFSET_W = 12;   // 4 KiB page offset
    localparam int PPN_W    = 22;   // physical page number
    localparam int ASID_W   = 9;    // address-space id in satp

    // pte flag bits, msb first
    typedef struct packed {
        logic [1:0] rsw;        // reserved for software
        logic       dirty;
        logic       accessed;
        logic       global;     // mapping shared by all asids
        logic       user;
        logic       executable;
        logic       writable;
        logic       readable;
        logic       valid;
    } sv32_perms_t;

    // leaf pte, 32 bits
    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        sv32_perms_t      perms;
    } sv32_pte_t;

    // walker word, seen raw or as a pte
    typedef union packed {
        logic [31:0] raw;
        sv32_pte_t   pte;
    } sv32_pte_word_u;

    // virtual address split
    typedef struct packed {
        logic [VPN_W-1:0]    vpn;
        logic [OFFSET_W-1:0] offset;   // not used for lookup
    } sv32_vaddr_t;

    // data-side access kind
    typedef enum logic {
        LOAD,
        STORE
    } access_e;

endpackage

// File: tb_tlb.sv
module tb_tlb;
    import sv32_pkg::*;
    import tlb_pkg::*;

    localparam int SETS     = 16;
    localparam int WAYS     = 2;
    localparam int ENTRIES  = SETS * WAYS;  // one sweep step each
    localparam int TIMEOUT  = 64;       // a fence needs 32 cycles
    localparam int NUM_ROWS = 27;
    localparam logic [1:0] OP_LOAD  = 2'd0;
    localparam logic [1:0] OP_STORE = 2'd1;
    localparam logic [1:0] OP_FENCE = 2'd2;
    localparam logic [1:0] OP_OFF   = 2'd3;    // load with translation off

    typedef struct packed {
        logic [1:0]  op;
        logic [31:0] va;        // request vaddr or fence va
        logic [8:0]  id;        // asid or fence asid
        logic [2:0]  delta;     // expected new walker requests
    } row_t;

    logic        CLK = 1'b0;
    logic        nRST = 1'b0;
    tlb_req_t    req = '0;
    logic [8:0]  asid = '0;
    logic        trans_on = 1'b1;
    logic        fence = 1'b0;
    sv32_vaddr_t fence_va = '0;
    logic [8:0]  fence_asid = '0;
    walk_rsp_t   walk_rsp = '{busy: 1'b1, rdata: 32'h0};  // idle walker reads busy
    logic        busy, tlb_miss, fence_done, fault_load, fault_store;
    logic [31:0] hit_pte;
    walk_req_t   walk_req;

    integer      seed = 32'h51cd061f;
    int          walk_count = 0;
    int          walk_left = 0;
    logic        walk_answer = 1'b0;
    int          done_pulses = 0;
    logic [31:0] got_pte;
    logic        got_fload, got_fstore, stayed_busy;
    logic        got_miss;      // tlb_miss seen during the access

    // A 0x00005, B 0x00105 and C 0x00205 all map to set 5
    // vpn 0x00047 is a global page
    row_t rows [NUM_ROWS] = '{
        '{OP_LOAD,  32'h0000_1abc, 9'd1, 3'd1},   // first load after sweep
        '{OP_LOAD,  32'h0000_1123, 9'd1, 3'd0},
        '{OP_STORE, 32'h0000_1123, 9'd1, 3'd0},   // not writable
        '{OP_LOAD,  32'h0001_2040, 9'd1, 3'd1},   // not readable
        '{OP_STORE, 32'h0001_2040, 9'd1, 3'd0},
        '{OP_STORE, 32'h0002_3800, 9'd1, 3'd1},   // writable and dirty
        '{OP_LOAD,  32'h0002_3800, 9'd1, 3'd0},
        '{OP_LOAD,  32'h0000_5000, 9'd1, 3'd1},   // A to way 1
        '{OP_LOAD,  32'h0010_5000, 9'd1, 3'd1},   // B to way 0
        '{OP_LOAD,  32'h0000_5000, 9'd1, 3'd0},
        '{OP_LOAD,  32'h0010_5000, 9'd1, 3'd0},   // mru now way 0
        '{OP_LOAD,  32'h0020_5000, 9'd1, 3'd1},   // C evicts A
        '{OP_LOAD,  32'h0010_5000, 9'd1, 3'd0},
        '{OP_LOAD,  32'h0000_5000, 9'd1, 3'd1},
        '{OP_FENCE, 32'h0000_1abc, 9'd0, 3'd0},   // by va only
        '{OP_LOAD,  32'h0000_1000, 9'd1, 3'd1},
        '{OP_LOAD,  32'h0001_2000, 9'd1, 3'd0},
        '{OP_LOAD,  32'h0004_7010, 9'd1, 3'd1},
        '{OP_FENCE, 32'h0000_0000, 9'd1, 3'd0},   // by asid with the global page kept
        '{OP_LOAD,  32'h0004_7010, 9'd1, 3'd0},
        '{OP_LOAD,  32'h0002_3000, 9'd1, 3'd1},
        '{OP_LOAD,  32'h0002_3000, 9'd2, 3'd1},   // other asid misses
        '{OP_LOAD,  32'h0002_3000, 9'd2, 3'd0},
        '{OP_OFF,   32'h0003_3000, 9'd1, 3'd0},
        '{OP_FENCE, 32'h0000_0000, 9'd0, 3'd0},   // everything
        '{OP_LOAD,  32'h0004_7010, 9'd1, 3'd1},
        '{OP_LOAD,  32'h0002_3000, 9'd2, 3'd1}
    };

    tlb #(.TLB_SETS(SETS), .TLB_WAYS(WAYS)) UUT (
        .CLK(CLK), .nRST(nRST), .req(req), .asid(asid), .trans_on(trans_on),
        .fence(fence), .fence_va(fence_va), .fence_asid(fence_asid),
        .walk_rsp(walk_rsp), .busy(busy), .hit_pte(hit_pte), .tlb_miss(tlb_miss),
        .fence_done(fence_done), .fault_load(fault_load), .fault_store(fault_store),
        .walk_req(walk_req)
    );

    always #4 CLK = ~CLK;

    // reference leaf pte for a vpn
    function automatic logic [31:0] ref_pte(input logic [19:0] vpn);
        logic [21:0] ppn;
        logic [9:0]  flags;
        ppn      = {2'b00, vpn} ^ 22'h15a5a;
        flags    = 10'b00_0100_0001;    // accessed and valid
        flags[1] = !vpn[4];             // readable
        flags[2] = vpn[5];              // writable
        flags[7] = vpn[5];              // dirty
        flags[5] = vpn[6];              // global
        return {ppn, flags};
    endfunction

    function automatic logic load_faults(input logic [31:0] pte);
        return !(pte[0] && pte[1] && pte[6]);   // needs v r a
    endfunction

    function automatic logic store_faults(input logic [31:0] pte);
        return !(pte[0] && pte[2] && pte[7]);   // needs v w d
    endfunction

    // page walker answers after 1..4 busy cycles
    always @(negedge CLK) begin
        if (walk_answer) begin
            walk_rsp.busy = 1'b1;
            walk_answer   = 1'b0;
        end else if (walk_left != 0) begin
            if (walk_left == 1) begin
                walk_rsp.busy  = 1'b0;
                walk_rsp.rdata = ref_pte(walk_req.addr[31:12]);
                walk_answer    = 1'b1;
            end
            walk_left = walk_left - 1;
        end else if (nRST && walk_req.ren) begin
            walk_count = walk_count + 1;
            walk_left  = 1 + int'($unsigned($random(seed)) % 4);
        end
    end

    always @(negedge CLK) begin
        if (fence_done)
            done_pulses = done_pulses + 1;  // depends on state only
    end

    task automatic access_tlb(input logic store, input logic [31:0] va,
                              input logic [8:0] id, output logic done);
        int cycles;
        @(negedge CLK);
        req.ren   = !store;
        req.wen   = store;
        req.vaddr = va;
        asid      = id;
        cycles    = 0;
        got_miss  = 1'b0;
        #2;
        got_miss = got_miss | tlb_miss;
        while (busy && cycles < TIMEOUT) begin
            @(negedge CLK);
            #2;
            got_miss = got_miss | tlb_miss;
            cycles++;
        end
        done       = !busy;
        got_pte    = hit_pte;     // valid only while busy is low
        got_fload  = fault_load;
        got_fstore = fault_store;
        @(negedge CLK);
        req = '0;
    endtask

    task automatic run_fence(input logic [31:0] va, input logic [8:0] id, output logic done);
        int cycles;
        @(negedge CLK);
        fence      = 1'b1;
        fence_va   = va;
        fence_asid = id;
        @(negedge CLK);
        fence  = 1'b0;            // one cycle pulse
        cycles = 0;
        #2;
        while (!fence_done && cycles < TIMEOUT) begin
            @(negedge CLK);
            #2;
            cycles++;
        end
        done = fence_done;
        @(negedge CLK);
        fence_va   = '0;
        fence_asid = '0;
    endtask

    // request with translation off watched over a fixed window
    task automatic check_off(input logic [31:0] va, input logic [8:0] id, output logic done);
        int cycles;
        @(negedge CLK);
        trans_on    = 1'b0;
        req.ren     = 1'b1;
        req.vaddr   = va;
        asid        = id;
        stayed_busy = 1'b1;
        got_miss    = 1'b0;
        for (cycles = 0; cycles < 8; cycles++) begin
            #2;
            if (!busy)
                stayed_busy = 1'b0;
            got_miss = got_miss | tlb_miss;
            @(negedge CLK);
        end
        req      = '0;
        trans_on = 1'b1;
        done     = 1'b1;
    endtask

    initial begin
        int          pass_cnt;
        int          fail_cnt;
        int          fence_cnt;
        int          count0;
        int          cycles;
        logic        done;
        logic        row_ok;
        logic        timed_out;
        logic [31:0] exp_pte;
        pass_cnt  = 0;
        fail_cnt  = 0;
        fence_cnt = 0;
        timed_out = 1'b0;
        repeat (4) @(negedge CLK);
        nRST   = 1'b1;
        cycles = 0;
        #2;
        while (!fence_done && cycles < TIMEOUT) begin   // reset sweep
            @(negedge CLK);
            #2;
            cycles++;
        end
        if (!fence_done) begin
            $display("reset sweep never finished, fence_done did not pulse");
            timed_out = 1'b1;
            fail_cnt++;
        end else begin
            // last entry is visited in the sweep's final cycle
            assert (done_pulses == 1 && busy && cycles == ENTRIES - 1) else begin
                $display("** Error at %0t: reset sweep took %0d cycles, pulses %0d, busy %b",
                         $time, cycles, done_pulses, busy);
                fail_cnt++;
            end
            if (fail_cnt == 0) begin
                $display("reset sweep passed");
                pass_cnt++;
            end
        end

        for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
            row_ok = 1'b1;
            count0 = walk_count;
            case (rows[i].op)
                OP_FENCE: run_fence(rows[i].va, rows[i].id, done);
                OP_OFF:   check_off(rows[i].va, rows[i].id, done);
                default:  access_tlb(rows[i].op == OP_STORE, rows[i].va, rows[i].id, done);
            endcase
            if (!done) begin
                $display("row %0d timed out waiting for the TLB at time %0t", i, $time);
                timed_out = 1'b1;
                row_ok    = 1'b0;
            end else begin
                if (rows[i].op == OP_FENCE)
                    fence_cnt++;
                assert (walk_count - count0 == int'(rows[i].delta)) else begin
                    $display("** Error at %0t: row %0d walker requests %0d, expected %0d",
                             $time, i, walk_count - count0, rows[i].delta);
                    row_ok = 1'b0;
                end
                if (rows[i].op != OP_FENCE) begin
                    assert (got_miss == (rows[i].delta != 0)) else begin
                        $display("** Error at %0t: row %0d tlb_miss %b, expected %b",
                                 $time, i, got_miss, rows[i].delta != 0);
                        row_ok = 1'b0;
                    end
                end
                if (rows[i].op == OP_OFF) begin
                    assert (stayed_busy) else begin
                        $display("** Error at %0t: row %0d busy dropped with translation off",
                                 $time, i);
                        row_ok = 1'b0;
                    end
                end else if (rows[i].op != OP_FENCE) begin
                    exp_pte = ref_pte(rows[i].va[31:12]);
                    assert (got_pte == exp_pte) else begin
                        $display("** Error at %0t: row %0d hit_pte %h, expected %h",
                                 $time, i, got_pte, exp_pte);
                        row_ok = 1'b0;
                    end
                    assert (got_fload == (rows[i].op == OP_LOAD && load_faults(exp_pte)) &&
                            got_fstore == (rows[i].op == OP_STORE && store_faults(exp_pte)))
                    else begin
                        $display("** Error at %0t: row %0d faults load %b store %b wrong",
                                 $time, i, got_fload, got_fstore);
                        row_ok = 1'b0;
                    end
                end
            end
            if (row_ok) begin
                $display("row %0d passed", i);
                pass_cnt++;
            end else begin
                fail_cnt++;
            end
        end

        assert (timed_out || done_pulses == 1 + fence_cnt) else begin
            $display("** Error at %0t: fence_done pulsed %0d times, expected %0d",
                     $time, done_pulses, 1 + fence_cnt);
            fail_cnt++;
        end
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: tlb.sv
module tlb #(
    parameter int TLB_SETS = 16,    // power of 2
    parameter int TLB_WAYS = 2
) (
    input  logic                        CLK,
    input  logic                        nRST,
    input  tlb_pkg::tlb_req_t           req,
    input  logic [sv32_pkg::ASID_W-1:0] asid,
    input  logic                        trans_on,
    input  logic                        fence,
    input  sv32_pkg::sv32_vaddr_t       fence_va,
    input  logic [sv32_pkg::ASID_W-1:0] fence_asid,
    input  tlb_pkg::walk_rsp_t          walk_rsp,
    output logic                        busy,
    output logic [31:0]                 hit_pte,
    output logic                        tlb_miss,
    output logic                        fence_done,
    output logic                        fault_load,
    output logic                        fault_store,
    output tlb_pkg::walk_req_t          walk_req
);
    import tlb_pkg::*;

    localparam int SET_W = (TLB_SETS > 1) ? $clog2(TLB_SETS) : 1;
    localparam int WAY_W = (TLB_WAYS > 1) ? $clog2(TLB_WAYS) : 1;

    tlb_entry_t [TLB_WAYS-1:0] set_a;       // request set, port a
    tlb_entry_t                entry_b;     // sweep entry, port b
    tlb_entry_t                hit_entry;
    tlb_entry_t                wr_entry;
    logic                      hit, kill, sweep_done, sweep_run, fence_mode;
    logic                      fill, wr_en;
    logic [WAY_W-1:0]          hit_way, victim_way, fill_way, sweep_way, wr_way;
    logic [SET_W-1:0]          sweep_set, wr_set;

    tlb_array #(.TLB_SETS(TLB_SETS), .TLB_WAYS(TLB_WAYS)) u_array (
        .CLK(CLK), .nRST(nRST),
        .rd_set_a(req.vaddr.vpn[SET_W-1:0]), .set_a(set_a),
        .rd_set_b(sweep_set), .rd_way_b(sweep_way), .entry_b(entry_b),
        .wr_en(wr_en), .wr_set(wr_set), .wr_way(wr_way), .wr_entry(wr_entry)
    );

    tlb_lookup #(.TLB_SETS(TLB_SETS), .TLB_WAYS(TLB_WAYS)) u_lookup (
        .CLK(CLK), .nRST(nRST),
        .vpn(req.vaddr.vpn), .asid(asid), .set_entries(set_a),
        .fill(fill), .fill_way(fill_way),
        .hit(hit), .hit_way(hit_way), .hit_entry(hit_entry), .victim_way(victim_way)
    );

    tlb_sweep #(.TLB_SETS(TLB_SETS), .TLB_WAYS(TLB_WAYS)) u_sweep (
        .CLK(CLK), .nRST(nRST),
        .run(sweep_run), .fence_mode(fence_mode),
        .fence_va(fence_va), .fence_asid(fence_asid), .entry(entry_b),
        .sweep_set(sweep_set), .sweep_way(sweep_way),
        .kill(kill), .sweep_done(sweep_done)
    );

    tlb_control #(.TLB_SETS(TLB_SETS), .TLB_WAYS(TLB_WAYS)) u_control (
        .CLK(CLK), .nRST(nRST),
        .req(req), .trans_on(trans_on), .asid(asid), .fence(fence),
        .hit(hit), .hit_way(hit_way), .hit_entry(hit_entry), .victim_way(victim_way),
        .kill(kill), .sweep_set(sweep_set), .sweep_way(sweep_way),
        .sweep_done(sweep_done), .walk_rsp(walk_rsp),
        .sweep_run(sweep_run), .fence_mode(fence_mode), .fill(fill), .fill_way(fill_way),
        .wr_en(wr_en), .wr_set(wr_set), .wr_way(wr_way), .wr_entry(wr_entry),
        .walk_req(walk_req), .busy(busy), .tlb_miss(tlb_miss), .fence_done(fence_done),
        .hit_pte(hit_pte), .fault_load(fault_load), .fault_store(fault_store)
    );

endmodule

// File: tlb_array.sv
module tlb_array #(
    parameter int TLB_SETS = 16,
    parameter int TLB_WAYS = 2,
    localparam int SET_W = (TLB_SETS > 1) ? $clog2(TLB_SETS) : 1,
    localparam int WAY_W = (TLB_WAYS > 1) ? $clog2(TLB_WAYS) : 1
) (
    input  logic                                CLK,
    input  logic                                nRST,
    input  logic [SET_W-1:0]                    rd_set_a,
    output tlb_pkg::tlb_entry_t [TLB_WAYS-1:0]  set_a,
    input  logic [SET_W-1:0]                    rd_set_b,
    input  logic [WAY_W-1:0]                    rd_way_b,
    output tlb_pkg::tlb_entry_t                 entry_b,
    input  logic                                wr_en,
    input  logic [SET_W-1:0]                    wr_set,
    input  logic [WAY_W-1:0]                    wr_way,
    input  tlb_pkg::tlb_entry_t                 wr_entry
);
    import tlb_pkg::*;

    localparam int PAYLOAD_W = $bits(tlb_entry_t) - 1;  // all but the valid bit

    logic [TLB_WAYS-1:0]  valid_q   [TLB_SETS];
    logic [PAYLOAD_W-1:0] payload_q [TLB_SETS][TLB_WAYS];  // asid, vpn, pte

    // valid bits, cleared on reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < TLB_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (wr_en) begin
            valid_q[wr_set][wr_way] <= wr_entry.tag.valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            payload_q[wr_set][wr_way] <= wr_entry[PAYLOAD_W-1:0];  // only the addressed way
        end
    end

    // port a, whole set for the lookup
    always_comb begin
        for (int w = 0; w < TLB_WAYS; w++) begin
            set_a[w] = tlb_entry_t'({valid_q[rd_set_a][w], payload_q[rd_set_a][w]});
        end
    end

    // port b, one entry for the sweep
    assign entry_b = tlb_entry_t'({valid_q[rd_set_b][rd_way_b], payload_q[rd_set_b][rd_way_b]});

endmodule

// File: tlb_control.sv
module tlb_control #(
    parameter int TLB_SETS = 16,
    parameter int TLB_WAYS = 2,
    localparam int SET_W = (TLB_SETS > 1) ? $clog2(TLB_SETS) : 1,
    localparam int WAY_W = (TLB_WAYS > 1) ? $clog2(TLB_WAYS) : 1
) (
    input  logic                        CLK,
    input  logic                        nRST,
    input  tlb_pkg::tlb_req_t           req,
    input  logic                        trans_on,
    input  logic [sv32_pkg::ASID_W-1:0] asid,
    input  logic                        fence,
    input  logic                        hit,
    input  logic [WAY_W-1:0]            hit_way,
    input  tlb_pkg::tlb_entry_t         hit_entry,
    input  logic [WAY_W-1:0]            victim_way,
    input  logic                        kill,
    input  logic [SET_W-1:0]            sweep_set,
    input  logic [WAY_W-1:0]            sweep_way,
    input  logic                        sweep_done,
    input  tlb_pkg::walk_rsp_t          walk_rsp,
    output logic                        sweep_run,
    output logic                        fence_mode,
    output logic                        fill,
    output logic [WAY_W-1:0]            fill_way,
    output logic                        wr_en,
    output logic [SET_W-1:0]            wr_set,
    output logic [WAY_W-1:0]            wr_way,
    output tlb_pkg::tlb_entry_t         wr_entry,
    output tlb_pkg::walk_req_t          walk_req,
    output logic                        busy,
    output logic                        tlb_miss,
    output logic                        fence_done,
    output logic [31:0]                 hit_pte,
    output logic                        fault_load,
    output logic                        fault_store
);
    import sv32_pkg::*;
    import tlb_pkg::*;

    tlb_state_e     state_q, state_d;
    sv32_vaddr_t    addr_q;         // missing vaddr, for the walker and the fill tag
    logic           latch_addr;
    logic           pte_chk;        // a hit result is being returned
    access_e        access;
    sv32_pte_word_u pte_word;       // result word, raw out and decoded for faults

    assign access   = req.wen ? STORE : LOAD;
    assign fill_way = victim_way;   // fills always go to the victim

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            state_q <= SWEEP_INIT;
        else
            state_q <= state_d;
    end

    always_ff @(posedge CLK) begin
        if (latch_addr)
            addr_q <= req.vaddr;
    end

    always_comb begin
        state_d       = state_q;
        sweep_run     = 1'b0;
        fence_mode    = 1'b0;
        fill          = 1'b0;
        wr_en         = 1'b0;
        wr_set        = sweep_set;
        wr_way        = sweep_way;
        wr_entry      = '0;         // cleared entry unless filling
        walk_req.ren  = 1'b0;
        walk_req.addr = addr_q;
        busy          = 1'b1;
        tlb_miss      = 1'b0;
        fence_done    = 1'b0;
        latch_addr    = 1'b0;
        pte_chk       = 1'b0;
        pte_word.raw  = '0;

        case (state_q)
            SWEEP_INIT: begin
                sweep_run = 1'b1;
                wr_en     = kill;   // always set outside fence mode
                if (sweep_done) begin
                    fence_done = 1'b1;
                    state_d    = HIT;
                end
            end
            HIT: begin
                if (fence) begin
                    state_d = FENCE;  // fence takes priority over a request
                end else if (trans_on && (req.ren || req.wen)) begin
                    if (hit) begin
                        busy         = 1'b0;
                        pte_chk      = 1'b1;
                        pte_word.pte = hit_entry.pte;
                    end else begin
                        tlb_miss   = 1'b1;
                        latch_addr = 1'b1;
                        state_d    = FETCH;
                    end
                end
            end
            FETCH: begin
                tlb_miss     = 1'b1;
                walk_req.ren = 1'b1;
                if (!walk_rsp.busy) begin
                    pte_word.raw       = walk_rsp.rdata;  // forwarded, busy still high
                    fill               = 1'b1;
                    wr_en              = 1'b1;
                    wr_set             = addr_q.vpn[SET_W-1:0];
                    wr_way             = victim_way;
                    wr_entry.tag.valid = 1'b1;
                    wr_entry.tag.asid  = asid;
                    wr_entry.tag.vpn   = addr_q.vpn;
                    wr_entry.pte       = pte_word.pte;
                    state_d            = HIT;  // next lookup hits
                end
            end
            FENCE: begin
                sweep_run  = 1'b1;
                fence_mode = 1'b1;
                wr_en      = kill;  // filtered by va / asid
                if (sweep_done) begin
                    fence_done = 1'b1;
                    state_d    = HIT;
                end
            end
            default: state_d = SWEEP_INIT;
        endcase
    end

    assign hit_pte = pte_word.raw;

    // permission faults, hits only
    assign fault_load  = pte_chk && (access == LOAD) &&
                         !(pte_word.pte.perms.valid && pte_word.pte.perms.readable &&
                           pte_word.pte.perms.accessed);
    assign fault_store = pte_chk && (access == STORE) &&
                         !(pte_word.pte.perms.valid && pte_word.pte.perms.writable &&
                           pte_word.pte.perms.dirty);

endmodule

// File: tlb_lookup.sv
module tlb_lookup #(
    parameter int TLB_SETS = 16,
    parameter int TLB_WAYS = 2,
    localparam int SET_W = (TLB_SETS > 1) ? $clog2(TLB_SETS) : 1,
    localparam int WAY_W = (TLB_WAYS > 1) ? $clog2(TLB_WAYS) : 1
) (
    input  logic                                CLK,
    input  logic                                nRST,
    input  logic [sv32_pkg::VPN_W-1:0]          vpn,
    input  logic [sv32_pkg::ASID_W-1:0]         asid,
    input  tlb_pkg::tlb_entry_t [TLB_WAYS-1:0]  set_entries,
    input  logic                                fill,
    input  logic [WAY_W-1:0]                    fill_way,
    output logic                                hit,
    output logic [WAY_W-1:0]                    hit_way,
    output tlb_pkg::tlb_entry_t                 hit_entry,
    output logic [WAY_W-1:0]                    victim_way
);

    logic [SET_W-1:0] set_idx;
    logic [WAY_W-1:0] mru_q [TLB_SETS];  // most recently used way per set

    assign set_idx = vpn[SET_W-1:0];  // low vpn bits pick the set

    // tag compare across the set
    always_comb begin
        hit       = 1'b0;
        hit_way   = '0;
        hit_entry = '0;
        for (int w = 0; w < TLB_WAYS; w++) begin
            if (set_entries[w].tag.valid &&
                set_entries[w].tag.vpn == vpn &&
                set_entries[w].tag.asid == asid) begin
                hit       = 1'b1;
                hit_way   = WAY_W'(w);
                hit_entry = set_entries[w];
            end
        end
    end

    // victim is the way after mru, wraps to 0
    always_comb begin
        if (TLB_WAYS == 1)
            victim_way = '0;
        else if (mru_q[set_idx] == WAY_W'(TLB_WAYS - 1))
            victim_way = '0;
        else
            victim_way = mru_q[set_idx] + 1'b1;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < TLB_SETS; s++) begin
                mru_q[s] <= '0;
            end
        end else if (fill) begin
            mru_q[set_idx] <= fill_way;  // fill wins over a stale hit
        end else if (hit) begin
            mru_q[set_idx] <= hit_way;
        end
    end

endmodule

// File: tlb_pkg.sv
package tlb_pkg;

    import sv32_pkg::*;

    // tag holds the whole vpn, so no dependency on set count
    typedef struct packed {
        logic              valid;
        logic [ASID_W-1:0] asid;
        logic [VPN_W-1:0]  vpn;
    } tlb_tag_t;

    // one stored translation, 30 + 32 = 62 bits
    // valid is the top bit of the entry
    typedef struct packed {
        tlb_tag_t  tag;
        sv32_pte_t pte;
    } tlb_entry_t;

    // pipeline request, held until busy drops
    typedef struct packed {
        logic        ren;   // load
        logic        wen;   // store
        sv32_vaddr_t vaddr;
    } tlb_req_t;

    // request to the page walker
    typedef struct packed {
        logic        ren;   // held through FETCH
        logic [31:0] addr;  // faulting vaddr
    } walk_req_t;

    // walker answer
    // busy low for exactly one cycle with rdata valid
    typedef struct packed {
        logic        busy;
        logic [31:0] rdata;
    } walk_rsp_t;

    // controller states
    typedef enum logic [1:0] {
        SWEEP_INIT,     // clear everything after reset
        HIT,            // normal lookup
        FETCH,          // waiting on the walker
        FENCE           // selective invalidate
    } tlb_state_e;

endpackage

// File: tlb_sweep.sv
module tlb_sweep #(
    parameter int TLB_SETS = 16,
    parameter int TLB_WAYS = 2,
    localparam int SET_W = (TLB_SETS > 1) ? $clog2(TLB_SETS) : 1,
    localparam int WAY_W = (TLB_WAYS > 1) ? $clog2(TLB_WAYS) : 1
) (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        run,
    input  logic                        fence_mode,
    input  sv32_pkg::sv32_vaddr_t       fence_va,
    input  logic [sv32_pkg::ASID_W-1:0] fence_asid,
    input  tlb_pkg::tlb_entry_t         entry,
    output logic [SET_W-1:0]            sweep_set,
    output logic [WAY_W-1:0]            sweep_way,
    output logic                        kill,
    output logic                        sweep_done
);

    localparam logic [SET_W-1:0] SET_LAST = SET_W'(TLB_SETS - 1);
    localparam logic [WAY_W-1:0] WAY_LAST = WAY_W'(TLB_WAYS - 1);

    logic [SET_W-1:0] set_q;
    logic [WAY_W-1:0] way_q;
    logic             last;     // counter on the final entry
    logic             va_match;
    logic             asid_match;

    assign sweep_set = set_q;
    assign sweep_way = way_q;

    assign last       = (set_q == SET_LAST) && (way_q == WAY_LAST);
    assign sweep_done = run && last;  // high in the cycle of the last entry

    // set-major walk, way is the fast digit
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            set_q <= '0;
            way_q <= '0;
        end else if (run) begin
            if (last) begin
                set_q <= '0;  // ready for the next sweep
                way_q <= '0;
            end else if (way_q == WAY_LAST) begin
                way_q <= '0;
                set_q <= set_q + 1'b1;
            end else begin
                way_q <= way_q + 1'b1;
            end
        end
    end

    // zero fence_va means all pages
    assign va_match = (fence_va == '0) || (entry.tag.vpn == fence_va.vpn);

    // zero fence_asid means all asids
    // global pages survive an asid fence
    assign asid_match = (fence_asid == '0) ||
                        (entry.tag.asid == fence_asid && !entry.pte.perms.global);

    // the reset sweep clears unconditionally
    always_comb begin
        if (fence_mode)
            kill = entry.tag.valid && va_match && asid_match;
        else
            kill = 1'b1;
    end

endmodule
